// ==== verilog/mdcsr_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared widths, opcodes and mcause values for the M/CSR pipeline
// operator and CSR access enums, stage payload structs
//////////////////////////////////////////////////////////////////////

`default_nettype none

package mdcsr_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int CSR_ADDR_W = 12;

  // major opcodes
  localparam logic [6:0] OPCODE_OP     = 7'b011_0011;
  localparam logic [6:0] OPCODE_SYSTEM = 7'b111_0011;

  localparam logic [XLEN-1:0] EXC_CAUSE_ILLEGAL_INSN = XLEN'(2);

  typedef enum logic [1:0] {
    MD_OP_MULL = 2'b00,
    MD_OP_MULH = 2'b01,
    MD_OP_DIV  = 2'b10,
    MD_OP_REM  = 2'b11
  } md_op_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef struct packed {
    logic is_csr;
    logic is_mult;
    logic is_div;
  } op_flags_t;

  // EX1 -> EX2, wdata is the CSR write value
  typedef struct packed {
    op_flags_t             flags;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       wdata;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       insn;
  } ex2_item_t;

  // EX2 -> WB -> commit
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
    logic                  err;
    logic [XLEN-1:0]       mcause;
    logic [XLEN-1:0]       pc;
  } pl_out_t;

endpackage

`default_nettype wire

// ==== verilog/md_if.sv ====
//////////////////////////////////////////////////////////////////////
// start and result signals between the pipeline stages and the
// multiplier / divider units
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface md_if
  import mdcsr_pkg::*;
();

  logic            mult_en;
  logic            div_en;
  md_op_e          operator;
  // bit 0: op_a signed, bit 1: op_b signed
  logic [1:0]      signed_mode;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] mult_result;
  logic [XLEN-1:0] div_result;
  logic            div_valid;

  modport ex1 (output mult_en, div_en, operator, signed_mode, op_a, op_b);
  modport mul (input mult_en, operator, signed_mode, op_a, op_b, output mult_result);
  modport div (input div_en, operator, signed_mode, op_a, op_b,
               output div_result, div_valid);
  modport ex2 (input mult_result, div_result, div_valid);

endinterface

`default_nettype wire

// ==== verilog/ex1_decode.sv ====
//////////////////////////////////////////////////////////////////////
// EX1 stage: RV32M and Zicsr decode, unit start strobes,
// CSR write value selection and the EX2 item
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ex1_decode
  import mdcsr_pkg::*;
(
  input  logic [XLEN-1:0] insn_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  input  logic            us_valid_i,
  input  logic            ex2_rdy_i,
  md_if.ex1               md,
  output ex2_item_t       item_o
);

  logic [6:0]      opcode;
  logic [6:0]      funct7;
  logic [2:0]      funct3;
  logic            is_md;
  logic            is_mult;
  logic            is_div;
  logic            is_csr;
  logic            start;
  logic [XLEN-1:0] csr_wdata;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];

  assign is_md   = (opcode == OPCODE_OP) && (funct7 == 7'b000_0001);
  assign is_mult = is_md & ~funct3[2];
  assign is_div  = is_md & funct3[2];
  // funct3 of zero is ecall/ebreak/mret and friends
  assign is_csr  = (opcode == OPCODE_SYSTEM) && (funct3 != 3'b000);

  always_comb begin
    if (funct3[2]) begin
      md.operator = funct3[1] ? MD_OP_REM : MD_OP_DIV;
    end else begin
      md.operator = (funct3[1:0] == 2'b00) ? MD_OP_MULL : MD_OP_MULH;
    end

    case (funct3)
      3'b001:  md.signed_mode = 2'b11;  // mulh
      3'b010:  md.signed_mode = 2'b01;  // mulhsu
      3'b100:  md.signed_mode = 2'b11;  // div
      3'b110:  md.signed_mode = 2'b11;  // rem
      default: md.signed_mode = 2'b00;
    endcase
  end

  // start only when the item really moves into EX2
  assign start      = us_valid_i & ex2_rdy_i;
  assign md.mult_en = start & is_mult;
  assign md.div_en  = start & is_div;
  assign md.op_a    = rs1_i;
  assign md.op_b    = rs2_i;

  // csrr*i forms use the zero-extended uimm field
  assign csr_wdata = insn_i[14] ? XLEN'(insn_i[19:15]) : rs1_i;

  assign item_o = '{
    flags: '{is_csr: is_csr, is_mult: is_mult, is_div: is_div},
    rf_we: is_csr | is_mult | is_div,
    rd:    insn_i[11:7],
    wdata: csr_wdata,
    pc:    pc_i,
    insn:  insn_i
  };

endmodule

`default_nettype wire

// ==== verilog/md_multiplier.sv ====
//////////////////////////////////////////////////////////////////////
// 32x32 multiplier, operands registered on mult_en,
// low or high word of the 64-bit product
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module md_multiplier
  import mdcsr_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  md_if.mul    md
);

  logic signed [XLEN:0]     op_a_q;
  logic signed [XLEN:0]     op_b_q;
  md_op_e                   operator_q;
  logic signed [2*XLEN-1:0] product;

  // one extra bit carries the sign for signed operands
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_a_q     <= '0;
      op_b_q     <= '0;
      operator_q <= MD_OP_MULL;
    end else if (md.mult_en) begin
      op_a_q     <= {md.signed_mode[0] & md.op_a[XLEN-1], md.op_a};
      op_b_q     <= {md.signed_mode[1] & md.op_b[XLEN-1], md.op_b};
      operator_q <= md.operator;
    end
  end

  assign product = (2*XLEN)'(op_a_q) * (2*XLEN)'(op_b_q);

  assign md.mult_result = (operator_q == MD_OP_MULH) ? product[2*XLEN-1:XLEN]
                                                     : product[XLEN-1:0];

endmodule

`default_nettype wire

// ==== verilog/md_divider.sv ====
//////////////////////////////////////////////////////////////////////
// iterative restoring divider, DIV_ITER quotient bits per cycle
// sign fix-up, divide-by-zero and signed overflow results
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module md_divider
  import mdcsr_pkg::*;
#(
  parameter int DIV_ITER = 1
) (
  input  logic clk_i,
  input  logic rst_ni,
  md_if.div    md
);

  localparam int STEPS = XLEN / DIV_ITER;
  localparam int CNT_W = $clog2(STEPS + 1);

  logic             busy_q;
  logic             valid_q;
  logic [CNT_W-1:0] cnt_q;

  logic [XLEN-1:0]  rem_q;
  logic [XLEN-1:0]  quot_q;
  logic [XLEN-1:0]  divisor_q;
  logic [XLEN-1:0]  dividend_q;
  md_op_e           operator_q;
  logic             neg_quot_q;
  logic             neg_rem_q;
  logic             div_zero_q;
  logic             overflow_q;

  logic             a_neg;
  logic             b_neg;
  logic [XLEN-1:0]  mag_a;
  logic [XLEN-1:0]  mag_b;
  logic [XLEN-1:0]  rem_nxt;
  logic [XLEN-1:0]  quot_nxt;
  logic [XLEN-1:0]  quot_res;
  logic [XLEN-1:0]  rem_res;

  assign a_neg = md.signed_mode[0] & md.op_a[XLEN-1];
  assign b_neg = md.signed_mode[1] & md.op_b[XLEN-1];
  assign mag_a = a_neg ? -md.op_a : md.op_a;
  assign mag_b = b_neg ? -md.op_b : md.op_b;

  // quotient register shifts the dividend out msb first
  always_comb begin : div_step
    logic [XLEN:0] shifted;
    logic [XLEN:0] trial;
    rem_nxt  = rem_q;
    quot_nxt = quot_q;
    for (int i = 0; i < DIV_ITER; i++) begin
      shifted = {rem_nxt, quot_nxt[XLEN-1]};
      trial   = shifted - {1'b0, divisor_q};
      if (!trial[XLEN]) begin
        rem_nxt  = trial[XLEN-1:0];
        quot_nxt = {quot_nxt[XLEN-2:0], 1'b1};
      end else begin
        rem_nxt  = shifted[XLEN-1:0];
        quot_nxt = {quot_nxt[XLEN-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else if (md.div_en) begin
      // a new start also abandons any running division
      busy_q  <= 1'b1;
      valid_q <= 1'b0;
      cnt_q   <= CNT_W'(STEPS);
    end else if (busy_q) begin
      cnt_q <= cnt_q - 1'b1;
      if (cnt_q == CNT_W'(1)) begin
        busy_q  <= 1'b0;
        valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (md.div_en) begin
      rem_q      <= '0;
      quot_q     <= mag_a;
      divisor_q  <= mag_b;
      dividend_q <= md.op_a;
      operator_q <= md.operator;
      neg_quot_q <= a_neg ^ b_neg;
      neg_rem_q  <= a_neg;
      div_zero_q <= (md.op_b == '0);
      overflow_q <= (md.signed_mode == 2'b11) && (md.op_a == {1'b1, {(XLEN-1){1'b0}}}) &&
                    (md.op_b == '1);
    end else if (busy_q) begin
      rem_q  <= rem_nxt;
      quot_q <= quot_nxt;
    end
  end

  // remainder takes the dividend's sign
  assign quot_res = div_zero_q ? '1 :
                    overflow_q ? dividend_q :
                    neg_quot_q ? -quot_q : quot_q;
  assign rem_res  = div_zero_q ? dividend_q :
                    overflow_q ? '0 :
                    neg_rem_q  ? -rem_q : rem_q;

  assign md.div_result = (operator_q == MD_OP_REM) ? rem_res : quot_res;
  assign md.div_valid  = valid_q;

endmodule

`default_nettype wire

// ==== verilog/ex2_stage.sv ====
//////////////////////////////////////////////////////////////////////
// EX2 stage: item register, completion tracking, CSR access port,
// illegal CSR error and result selection
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ex2_stage
  import mdcsr_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,

  input  logic                  us_valid_i,
  input  ex2_item_t             item_i,
  md_if.ex2                     md,

  input  logic                  wb_rdy_i,
  output logic                  ex2_rdy_o,
  output logic                  ex2wb_valid_o,
  output pl_out_t               ex2wb_o,

  output logic                  csr_op_en_o,
  output csr_op_e               csr_op_o,
  output logic [CSR_ADDR_W-1:0] csr_addr_o,
  output logic [XLEN-1:0]       csr_wdata_o,
  input  logic [XLEN-1:0]       csr_rdata_i,
  input  logic                  illegal_csr_i
);

  logic            valid_q;
  ex2_item_t       item_q;
  logic            done_q;
  logic            op_done;
  logic            rs1_zero;
  logic            err;
  logic [XLEN-1:0] result;

  // only a division takes more than one cycle
  assign op_done = ~item_q.flags.is_div | md.div_valid | done_q;

  assign ex2_rdy_o     = ~valid_q | (op_done & wb_rdy_i);
  assign ex2wb_valid_o = valid_q & op_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      if (flush_i) begin
        valid_q <= 1'b0;
      end else if (ex2_rdy_o) begin
        valid_q <= us_valid_i;
      end

      // keep done while WB stalls us
      if (flush_i || ex2_rdy_o) begin
        done_q <= 1'b0;
      end else if (valid_q && op_done) begin
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex2_rdy_o) begin
      item_q <= item_i;
    end
  end

  // CSR access stays up while the item waits
  assign csr_op_en_o = valid_q & item_q.flags.is_csr;
  assign csr_addr_o  = item_q.insn[31:20];
  assign csr_wdata_o = item_q.wdata;
  assign rs1_zero    = (item_q.insn[19:15] == '0);

  always_comb begin
    case (item_q.insn[13:12])
      2'b01:   csr_op_o = CSR_OP_WRITE;
      2'b10:   csr_op_o = rs1_zero ? CSR_OP_READ : CSR_OP_SET;
      2'b11:   csr_op_o = rs1_zero ? CSR_OP_READ : CSR_OP_CLEAR;
      default: csr_op_o = CSR_OP_READ;
    endcase
  end

  always_comb begin
    if (item_q.flags.is_csr) begin
      result = csr_rdata_i;
    end else if (item_q.flags.is_mult) begin
      result = md.mult_result;
    end else if (item_q.flags.is_div) begin
      result = md.div_result;
    end else begin
      result = '0;
    end
  end

  assign err = item_q.flags.is_csr & illegal_csr_i;

  assign ex2wb_o = '{
    we:     item_q.rf_we,
    waddr:  item_q.rd,
    wdata:  result,
    err:    err,
    mcause: err ? EXC_CAUSE_ILLEGAL_INSN : '0,
    pc:     item_q.pc
  };

endmodule

`default_nettype wire

// ==== verilog/wb_stage.sv ====
//////////////////////////////////////////////////////////////////////
// WB stage: output register towards commit with flush
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module wb_stage
  import mdcsr_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    flush_i,
  input  logic    ex2wb_valid_i,
  input  pl_out_t ex2wb_i,
  input  logic    ds_rdy_i,
  output logic    wb_rdy_o,
  output logic    mult_pl_valid_o,
  output pl_out_t mult_pl_out_o
);

  logic    valid_q;
  pl_out_t out_q;

  assign wb_rdy_o = ~valid_q | ds_rdy_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (wb_rdy_o) begin
      valid_q <= ex2wb_valid_i;
    end
  end

  // payload frozen while commit holds off
  always_ff @(posedge clk_i) begin
    if (wb_rdy_o && ex2wb_valid_i) begin
      out_q <= ex2wb_i;
    end
  end

  assign mult_pl_valid_o = valid_q;
  assign mult_pl_out_o   = out_q;

endmodule

`default_nettype wire

// ==== verilog/mult_pipeline.sv ====
//////////////////////////////////////////////////////////////////////
// multiply/divide and CSR pipeline top level
// EX1 decode, EX2, WB and the two arithmetic units
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module mult_pipeline
  import mdcsr_pkg::*;
#(
  parameter int DIV_ITER = 1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,

  // issuer side
  input  logic                  us_valid_i,
  input  logic [XLEN-1:0]       insn_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [XLEN-1:0]       rs1_i,
  input  logic [XLEN-1:0]       rs2_i,
  output logic                  mult_pl_rdy_o,

  // commit side
  input  logic                  ds_rdy_i,
  output logic                  mult_pl_valid_o,
  output pl_out_t               mult_pl_out_o,

  // CSR file access
  output logic                  csr_op_en_o,
  output csr_op_e               csr_op_o,
  output logic [CSR_ADDR_W-1:0] csr_addr_o,
  output logic [XLEN-1:0]       csr_wdata_o,
  input  logic [XLEN-1:0]       csr_rdata_i,
  input  logic                  illegal_csr_i
);

  logic      ex2_rdy;
  ex2_item_t ex2_item;
  logic      ex2wb_valid;
  pl_out_t   ex2wb;
  logic      wb_rdy;

  md_if u_md_if ();

  assign mult_pl_rdy_o = ex2_rdy;

  ex1_decode u_ex1_decode (
    .insn_i     (insn_i),
    .pc_i       (pc_i),
    .rs1_i      (rs1_i),
    .rs2_i      (rs2_i),
    .us_valid_i (us_valid_i),
    .ex2_rdy_i  (ex2_rdy),
    .md         (u_md_if.ex1),
    .item_o     (ex2_item)
  );

  md_multiplier u_md_multiplier (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .md     (u_md_if.mul)
  );

  md_divider #(
    .DIV_ITER (DIV_ITER)
  ) u_md_divider (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .md     (u_md_if.div)
  );

  ex2_stage u_ex2_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .us_valid_i    (us_valid_i),
    .item_i        (ex2_item),
    .md            (u_md_if.ex2),
    .wb_rdy_i      (wb_rdy),
    .ex2_rdy_o     (ex2_rdy),
    .ex2wb_valid_o (ex2wb_valid),
    .ex2wb_o       (ex2wb),
    .csr_op_en_o   (csr_op_en_o),
    .csr_op_o      (csr_op_o),
    .csr_addr_o    (csr_addr_o),
    .csr_wdata_o   (csr_wdata_o),
    .csr_rdata_i   (csr_rdata_i),
    .illegal_csr_i (illegal_csr_i)
  );

  wb_stage u_wb_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .ex2wb_valid_i   (ex2wb_valid),
    .ex2wb_i         (ex2wb),
    .ds_rdy_i        (ds_rdy_i),
    .wb_rdy_o        (wb_rdy),
    .mult_pl_valid_o (mult_pl_valid_o),
    .mult_pl_out_o   (mult_pl_out_o)
  );

endmodule

`default_nettype wire

// ==== verif/tb_mult_pipeline.sv ====
//////////////////////////////////////////////////////////////////////
// M/CSR pipeline testbench with reference models, CSR file model,
// compare tasks, directed tests and watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_mult_pipeline
  import mdcsr_pkg::*;
();

  localparam int N_ITEMS  = 40 + 32 + 8 + 2 + 30 + 3;
  localparam int N_STREAM = 30;
  localparam int WAIT_MAX = 200;

  // Zicsr funct3 codes
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;
  localparam logic [2:0] CSR_SEQ [8] = '{F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI,
                                         F3_CSRRSI, F3_CSRRCI, F3_CSRRS, F3_CSRRCI};

  localparam logic [31:0] CORNER_A [4] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h0};
  localparam logic [31:0] CORNER_B [4] = '{32'hFFFF_FFFF, 32'h8000_0000, 32'h2, 32'h12345};

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  us_valid_i;
  logic [XLEN-1:0]       insn_i;
  logic [XLEN-1:0]       pc_i;
  logic [XLEN-1:0]       rs1_i;
  logic [XLEN-1:0]       rs2_i;
  logic                  mult_pl_rdy_o;
  logic                  ds_rdy_i;
  logic                  mult_pl_valid_o;
  pl_out_t               mult_pl_out_o;
  logic                  csr_op_en_o;
  csr_op_e               csr_op_o;
  logic [CSR_ADDR_W-1:0] csr_addr_o;
  logic [XLEN-1:0]       csr_wdata_o;
  logic [XLEN-1:0]       csr_rdata_i;
  logic                  illegal_csr_i;

  logic        acc_q      = 1'b0;
  logic        out_xfer_q = 1'b0;
  pl_out_t     out_cap_q;
  logic [31:0] lcg_state  = 32'd20;
  logic [31:0] csr_mem [0:2047];
  pl_out_t     exp_q [$];

  always #5 clk_i = ~clk_i;

  mult_pipeline #(
    .DIV_ITER (1)
  ) u_mult_pipeline (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .us_valid_i      (us_valid_i),
    .insn_i          (insn_i),
    .pc_i            (pc_i),
    .rs1_i           (rs1_i),
    .rs2_i           (rs2_i),
    .mult_pl_rdy_o   (mult_pl_rdy_o),
    .ds_rdy_i        (ds_rdy_i),
    .mult_pl_valid_o (mult_pl_valid_o),
    .mult_pl_out_o   (mult_pl_out_o),
    .csr_op_en_o     (csr_op_en_o),
    .csr_op_o        (csr_op_o),
    .csr_addr_o      (csr_addr_o),
    .csr_wdata_o     (csr_wdata_o),
    .csr_rdata_i     (csr_rdata_i),
    .illegal_csr_i   (illegal_csr_i)
  );

  // CSR file model answering in the same cycle
  assign illegal_csr_i = (csr_addr_o > 12'h7FF);
  assign csr_rdata_i   = illegal_csr_i ? '0 : csr_mem[csr_addr_o[10:0]];

  // update when the CSR item leaves EX2
  always @(posedge clk_i) begin
    if (csr_op_en_o && mult_pl_rdy_o && !flush_i && !illegal_csr_i) begin
      case (csr_op_o)
        CSR_OP_WRITE: csr_mem[csr_addr_o[10:0]] <= csr_wdata_o;
        CSR_OP_SET:   csr_mem[csr_addr_o[10:0]] <= csr_rdata_i | csr_wdata_o;
        CSR_OP_CLEAR: csr_mem[csr_addr_o[10:0]] <= csr_rdata_i & ~csr_wdata_o;
        default:      ;
      endcase
    end
  end

  // handshakes seen at the rising edge
  always @(posedge clk_i) begin
    acc_q      <= us_valid_i & mult_pl_rdy_o;
    out_xfer_q <= mult_pl_valid_o & ds_rdy_i;
    out_cap_q  <= mult_pl_out_o;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] mul_ref(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    ea = (f3[1:0] == 2'b01 || f3[1:0] == 2'b10) ? {{32{a[31]}}, a} : {32'h0, a};
    eb = (f3[1:0] == 2'b01) ? {{32{b[31]}}, b} : {32'h0, b};
    p  = ea * eb;
    return (f3[1:0] == 2'b00) ? p[31:0] : p[63:32];
  endfunction

  function automatic logic [31:0] div_ref(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [31:0] q;
    logic [31:0] r;
    if (b == 32'h0) begin
      q = '1;
      r = a;
    end else if (!f3[0] && a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
      q = a;
      r = '0;
    end else if (!f3[0]) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return f3[1] ? r : q;
  endfunction

  function automatic pl_out_t exp_out(input logic we, input logic [4:0] rd,
                                      input logic [31:0] wdata, input logic err,
                                      input logic [31:0] pc);
    pl_out_t o;
    o.we     = we;
    o.waddr  = rd;
    o.wdata  = wdata;
    o.err    = err;
    o.mcause = err ? EXC_CAUSE_ILLEGAL_INSN : '0;
    o.pc     = pc;
    return o;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  task automatic check_out(input pl_out_t got, input pl_out_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Error at %0t: %s got we=%0b rd=%0d wdata=%h err=%0b mcause=%h pc=%h, %s",
                         $time, what, got.we, got.waddr, got.wdata, got.err, got.mcause, got.pc,
                         $sformatf("expected we=%0b rd=%0d wdata=%h err=%0b mcause=%h pc=%h",
                                   exp.we, exp.waddr, exp.wdata, exp.err, exp.mcause,
                                   exp.pc)));
    end
  endtask

  task automatic check_csr(input csr_op_e op, input logic [11:0] addr,
                           input logic [31:0] wdata);
    if (csr_op_en_o !== 1'b1 || csr_op_o !== op || csr_addr_o !== addr ||
        csr_wdata_o !== wdata) begin
      stop_run($sformatf("Error at %0t: CSR port en=%0b op=%0d addr=%h wdata=%h, %s",
                         $time, csr_op_en_o, csr_op_o, csr_addr_o, csr_wdata_o,
                         $sformatf("expected op=%0d addr=%h wdata=%h", op, addr, wdata)));
    end
  endtask

  // runs from a falling edge to the falling edge after acceptance
  task automatic send_item(input logic [31:0] insn, input logic [31:0] rs1,
                           input logic [31:0] rs2, input logic [31:0] pc);
    int n;
    n          = 0;
    us_valid_i = 1'b1;
    insn_i     = insn;
    rs1_i      = rs1;
    rs2_i      = rs2;
    pc_i       = pc;
    do begin
      @(negedge clk_i);
      n++;
      if (n > WAIT_MAX) stop_run("upstream ready never came while sending an item");
    end while (!acc_q);
    us_valid_i = 1'b0;
  endtask

  task automatic recv_check(input pl_out_t exp, input string what);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > WAIT_MAX) stop_run("no output came out of the pipeline");
    end while (!out_xfer_q);
    check_out(out_cap_q, exp, what);
  endtask

  function automatic logic [31:0] md_insn(input logic [2:0] f3, input logic [4:0] rd);
    return {7'b000_0001, 5'd2, 5'd1, f3, rd, OPCODE_OP};
  endfunction

  task automatic run_md(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
    logic [4:0]  rd;
    logic [31:0] pc;
    logic [31:0] res;
    rd  = 5'(next_rand() >> 27);
    pc  = next_rand() & 32'hFFFF_FFFC;
    res = f3[2] ? div_ref(f3, a, b) : mul_ref(f3, a, b);
    send_item(md_insn(f3, rd), a, b, pc);
    recv_check(exp_out(1'b1, rd, res, 1'b0, pc), f3[2] ? "div" : "mul");
  endtask

  task automatic mul_forms();
    for (int f = 0; f < 4; f++) begin
      for (int i = 0; i < 4; i++) run_md(3'(f), CORNER_A[i], CORNER_B[i]);
      for (int i = 0; i < 6; i++) run_md(3'(f), next_rand(), next_rand());
    end
  endtask

  task automatic div_forms();
    for (int f = 4; f < 8; f++) begin
      for (int i = 0; i < 6; i++) run_md(3'(f), next_rand(), next_rand() >> (i * 5));
      run_md(3'(f), next_rand(), 32'h0);
      run_md(3'(f), 32'h8000_0000, 32'hFFFF_FFFF);
    end
  endtask

  task automatic csr_instructions();
    logic [2:0]  f3;
    logic [4:0]  rs1f;
    logic [4:0]  rd;
    logic [11:0] addr;
    logic [31:0] rs1v;
    logic [31:0] pc;
    logic [31:0] wd;
    csr_op_e     op;
    for (int k = 0; k < 8; k++) begin
      f3   = CSR_SEQ[k];
      rs1f = (k >= 6) ? 5'd0 : (5'(next_rand() >> 27) | 5'd1);
      rd   = 5'(next_rand() >> 27);
      addr = 12'h300 + 12'(k % 3);
      rs1v = next_rand();
      pc   = next_rand() & 32'hFFFF_FFFC;
      send_item({addr, rs1f, f3, rd, OPCODE_SYSTEM}, rs1v, 32'h0, pc);
      if (f3[1:0] == 2'b01) op = CSR_OP_WRITE;
      else if (rs1f == 5'd0) op = CSR_OP_READ;
      else op = (f3[1:0] == 2'b10) ? CSR_OP_SET : CSR_OP_CLEAR;
      wd = f3[2] ? {27'h0, rs1f} : rs1v;
      check_csr(op, addr, wd);
      recv_check(exp_out(1'b1, rd, csr_mem[addr[10:0]], 1'b0, pc), "csr");
    end
  endtask

  task automatic illegal_csr_access();
    logic [11:0] addr;
    logic [31:0] rs1v;
    for (int k = 0; k < 2; k++) begin
      addr = (k == 0) ? 12'h800 : 12'hFFF;
      rs1v = next_rand();
      send_item({addr, 5'd3, F3_CSRRS, 5'd9, OPCODE_SYSTEM}, rs1v, 32'h0, 32'h100);
      check_csr(CSR_OP_SET, addr, rs1v);
      recv_check(exp_out(1'b1, 5'd9, 32'h0, 1'b1, 32'h100), "illegal csr");
    end
  endtask

  task automatic backpressure_stream();
    int got_n;
    int stretch;
    got_n   = 0;
    stretch = 0;
    fork
      begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        for (int i = 0; i < N_STREAM; i++) begin
          a  = next_rand();
          b  = next_rand();
          pc = 32'h2000 + 32'(i * 4);
          rd = 5'(i);
          f3 = 3'(next_rand() >> 29);
          if (i % 5 == 4) begin
            // plain add passes through with result 0
            exp_q.push_back(exp_out(1'b0, rd, 32'h0, 1'b0, pc));
            send_item({7'b0, 5'd2, 5'd1, 3'b000, rd, OPCODE_OP}, a, b, pc);
          end else begin
            exp_q.push_back(exp_out(1'b1, rd, f3[2] ? div_ref(f3, a, b) : mul_ref(f3, a, b),
                                    1'b0, pc));
            send_item(md_insn(f3, rd), a, b, pc);
          end
        end
      end
      begin
        while (got_n < N_STREAM) begin
          @(negedge clk_i);
          if (out_xfer_q) begin
            if (exp_q.size() == 0) stop_run("an output appeared with nothing expected");
            check_out(out_cap_q, exp_q.pop_front(), "stream");
            got_n++;
          end
          if (stretch == 0) begin
            ds_rdy_i = next_rand() > 32'h6000_0000;
            stretch  = int'(next_rand() >> 29) + 1;
          end
          stretch--;
        end
      end
    join
    ds_rdy_i = 1'b1;
  endtask

  task automatic flush_during_div();
    // one item parked in WB and a division running in EX2
    ds_rdy_i = 1'b0;
    send_item(md_insn(3'b000, 5'd4), 32'd7, 32'd6, 32'h400);
    send_item(md_insn(3'b100, 5'd5), next_rand(), 32'd3, 32'h404);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i  = 1'b0;
    ds_rdy_i = 1'b1;
    repeat (5) begin
      @(negedge clk_i);
      if (out_xfer_q || mult_pl_valid_o) stop_run("a flushed item came out of the pipeline");
    end
    // restart the divider while the abandoned run is still busy
    run_md(3'b110, next_rand(), next_rand() >> 4);
  endtask

  initial begin
    repeat (16 + N_ITEMS * 60) @(posedge clk_i);
    stop_run("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    for (int i = 0; i < 2048; i++) csr_mem[i] = 32'hC5A0_0000 ^ (32'(i) * 32'h0001_0003);
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    us_valid_i = 1'b0;
    insn_i     = '0;
    pc_i       = '0;
    rs1_i      = '0;
    rs2_i      = '0;
    ds_rdy_i   = 1'b1;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    mul_forms();
    div_forms();
    csr_instructions();
    illegal_csr_access();
    backpressure_stream();
    flush_during_div();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/mdcsr_pkg.sv
verilog/md_if.sv
verilog/ex1_decode.sv
verilog/md_multiplier.sv
verilog/md_divider.sv
verilog/ex2_stage.sv
verilog/wb_stage.sv
verilog/mult_pipeline.sv
verif/tb_mult_pipeline.sv

// ==== Makefile ====
# Verilator build and run of the M/CSR pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_mult_pipeline
SIM_DIR   ?= obj_dir
FLIST     ?= list.f

VFLAGS ?= --binary --timing -f $(FLIST) --top-module $(TOP) -Mdir $(SIM_DIR)

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS)

run: build
	./$(SIM_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(SIM_DIR)
